// File: cache_input.txt
# op (0 load, 1 store) size (0 byte, 1 half, 2 word) addr wdata hit (0, 1, 2 unchecked)
# data is aligned in its word lanes
0 2 00001000 00000000 0
0 2 00001004 00000000 1
0 0 00001005 00000000 1
0 1 00001006 00000000 1
1 0 00001001 0000ab00 1
0 2 00001000 00000000 1
1 1 00001006 beef0000 1
0 1 00001006 00000000 1
1 2 00002008 12345678 0
0 2 00002008 00000000 1
0 0 0000200b 00000000 1
1 2 00003010 cafef00d 0
0 2 00003210 00000000 0
0 2 00003410 00000000 0
0 2 00003610 00000000 0
0 2 00003810 00000000 0
0 2 00003010 00000000 2
0 2 00003014 00000000 2
0 2 00004020 00000000 0
0 2 00004220 00000000 0
0 2 00004020 00000000 1
1 0 00004223 5a000000 1
0 2 00004220 00000000 1
0 1 00004022 00000000 1
1 0 00005002 00770000 2
0 2 00005000 00000000 2
1 1 00005204 00001234 2
0 1 00005204 00000000 2
0 2 00005402 00000000 2
0 2 00005400 00000000 2
1 2 00005000 0badc0de 2
0 0 00005003 00000000 2
0 2 00005200 00000000 2
0 2 00005000 00000000 2

// File: tb.f
cache_pkg.sv
lfsr_8bit.sv
tag_array.sv
data_array.sv
cache_ctrl.sv
cache_top.sv
cache_assertions.sv
tb_clock.sv
tb_mem.sv
tb_cache.sv

// File: Makefile
VERILATOR ?= verilator
TOP       ?= tb_cache
FILELIST  ?= tb.f
BUILD_DIR ?= obj_dir
VFLAGS    ?= --binary --timing --assert

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with Verilator and run the testbench"
	@echo "  clean  remove the build directory"
	@echo "variables: VERILATOR TOP FILELIST BUILD_DIR VFLAGS"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR)
	./$(BUILD_DIR)/V$(TOP)

clean:
	rm -rf $(BUILD_DIR)

// File: tb_cache.sv
`timescale 1ns/1ps
`default_nettype none

module tb_cache;

    localparam int TIMEOUT = 200; // cycles per wait

    logic                 clk;
    logic                 init;
    logic                 cpu_req_valid;
    cache_pkg::cpu_req_t  cpu_req;
    logic                 cpu_ack;
    cache_pkg::cpu_resp_t cpu_resp;
    logic                 mem_req_valid;
    cache_pkg::mem_req_t  mem_req;
    logic                 mem_ack;
    cache_pkg::block_t    mem_rdata;

    logic [7:0] ref_mem [cache_pkg::addr_t]; // bytes written by stores

    tb_clock clk0 (.clk(clk), .init(init));

    tb_mem mem0 (
        .clk           (clk),
        .init          (init),
        .mem_req_valid (mem_req_valid),
        .mem_req       (mem_req),
        .mem_ack       (mem_ack),
        .mem_rdata     (mem_rdata)
    );

    cache_top dut0 (
        .clk           (clk),
        .init          (init),
        .cpu_req_valid (cpu_req_valid),
        .cpu_req       (cpu_req),
        .cpu_ack       (cpu_ack),
        .cpu_resp      (cpu_resp),
        .mem_req_valid (mem_req_valid),
        .mem_req       (mem_req),
        .mem_ack       (mem_ack),
        .mem_rdata     (mem_rdata)
    );

    task automatic stop_run(input string msg);
        $display("%s", msg);
        $display("Checks failed");
        $fatal(1, "simulation stopped on error");
    endtask

    function automatic logic [7:0] byte_at(input cache_pkg::addr_t a);
        cache_pkg::addr_t w;
        logic [31:0]      v;
        if (ref_mem.exists(a)) return ref_mem[a];
        w = {a[31:2], 2'b00};
        v = {w[15:0], ~w[31:16]} ^ 32'h5a3c_96e1; // initial memory pattern
        return v[8*a[1:0] +: 8];
    endfunction

    // zero extended load of 1, 2 or 4 bytes
    function automatic cache_pkg::word_t expected_load(input cache_pkg::addr_t a,
                                                       input cache_pkg::size_t sz);
        cache_pkg::word_t v;
        v = '0;
        for (int i = 0; i < (1 << sz); i++) v[8*i +: 8] = byte_at(a + i);
        return v;
    endfunction

    task automatic wait_ack(input logic level, output int cycles);
        cycles = 0;
        while (cpu_ack !== level) begin
            @(negedge clk);
            cycles++;
            if (cycles > TIMEOUT) stop_run($sformatf("timeout waiting for cpu_ack to be %0b", level));
        end
    endtask

    task automatic do_access(input int op, input int sz, input cache_pkg::addr_t a,
                             input cache_pkg::word_t wd, input int exp_hit);
        int               cycles;
        int               drop_cycles;
        cache_pkg::word_t expect_word;
        if (exp_hit == 2) repeat ($urandom_range(3, 0)) @(posedge clk);
        @(posedge clk);
        cpu_req       <= '{write: op[0], size: sz[1:0], addr: a, wdata: wd};
        cpu_req_valid <= 1'b1;
        wait_ack(1'b1, cycles);
        if (op == 0) begin
            expect_word = expected_load(a, sz[1:0]);
            assert (cpu_resp.rdata == expect_word)
                else stop_run($sformatf("FAIL %0t: load %h size %0d got %h, expected %h",
                                        $time, a, sz, cpu_resp.rdata, expect_word));
            // req is seen one edge after the drive and ack at the negedge after it rises
            if (exp_hit == 1) begin
                assert (cycles == 4)
                    else stop_run($sformatf("FAIL %0t: hit latency %0d at %h",
                                            $time, cycles - 2, a));
            end
        end else begin
            for (int i = 0; i < (1 << sz); i++) ref_mem[a + i] = wd[8*(a[1:0] + i) +: 8];
        end
        if (exp_hit != 2) begin
            assert (cpu_resp.hit == exp_hit[0])
                else stop_run($sformatf("FAIL %0t: hit flag %0b at %h, expected %0d",
                                        $time, cpu_resp.hit, a, exp_hit));
        end
        drop_cycles = (exp_hit == 2) ? $urandom_range(3, 0) : 0; // slow pipeline
        repeat (drop_cycles) @(posedge clk);
        @(posedge clk);
        cpu_req_valid <= 1'b0;
        wait_ack(1'b0, cycles);
    endtask

    initial begin
        int    fd;
        int    n;
        int    op;
        int    sz;
        int    exp_hit;
        int    waited;
        logic [31:0] a;
        logic [31:0] wd;
        string line;
        cpu_req_valid = 1'b0;
        cpu_req       = '0;
        void'($urandom(32'h3a51_9f12));
        waited = 0;
        while (init !== 1'b0) begin
            @(negedge clk);
            waited++;
            if (waited > TIMEOUT) stop_run("reset never released");
        end
        assert (!cpu_ack && !mem_req_valid)
            else stop_run($sformatf("FAIL %0t: handshake outputs high after reset", $time));
        fd = $fopen("cache_input.txt", "r");
        if (fd == 0) stop_run("cannot open cache_input.txt");
        while (!$feof(fd)) begin
            n = $fgets(line, fd);
            if (n == 0 || line.len() < 2 || line.getc(0) == "#") continue;
            n = $sscanf(line, "%d %d %h %h %d", op, sz, a, wd, exp_hit);
            if (n != 5) continue;
            // the pipeline never sends misaligned accesses
            if ((a & ((32'd1 << sz) - 32'd1)) != 0) continue;
            do_access(op, sz, a, wd, exp_hit);
        end
        $fclose(fd);
        repeat (4) @(posedge clk);
        if (dut0.ctrl0.chk0.fail_count == 0) begin
            $display("All checks passed");
            $finish;
        end else begin
            stop_run("a protocol assertion failed");
        end
    end

endmodule

`default_nettype wire

// File: tb_mem.sv
`timescale 1ns/1ps
`default_nettype none

// behavioral main memory, one block per request
module tb_mem (
    input  logic                clk,
    input  logic                init,
    input  logic                mem_req_valid,
    input  cache_pkg::mem_req_t mem_req,
    output logic                mem_ack,
    output cache_pkg::block_t   mem_rdata
);

    cache_pkg::block_t mem [cache_pkg::blk_addr_t]; // sparse, only written blocks
    logic              busy;
    logic [2:0]        count;

    // each word holds a pattern of its own address
    function automatic cache_pkg::block_t pattern_block(input cache_pkg::blk_addr_t a);
        cache_pkg::block_t b;
        cache_pkg::addr_t  w;
        for (int h = 0; h < 2; h++) begin
            w = {a, h[0], 2'b00};
            b[32*h +: 32] = {w[15:0], ~w[31:16]} ^ 32'h5a3c_96e1;
        end
        return b;
    endfunction

    always @(posedge clk or posedge init) begin
        if (init) begin
            mem_ack   <= 1'b0;
            mem_rdata <= '0;
            busy      <= 1'b0;
            count     <= '0;
        end else if (!mem_ack && mem_req_valid) begin
            if (!busy) begin
                busy  <= 1'b1;
                count <= 3'($urandom_range(5, 0)); // ack 1 to 6 cycles later
            end else if (count != 0) begin
                count <= count - 3'd1;
            end else begin
                busy    <= 1'b0;
                mem_ack <= 1'b1;
                if (mem_req.write) begin
                    mem[mem_req.blk_addr] = mem_req.wdata;
                end else if (mem.exists(mem_req.blk_addr)) begin
                    mem_rdata <= mem[mem_req.blk_addr];
                end else begin
                    mem_rdata <= pattern_block(mem_req.blk_addr);
                end
            end
        end else if (mem_ack && !mem_req_valid) begin
            mem_ack <= 1'b0;
        end
    end

endmodule

`default_nettype wire

// File: tb_clock.sv
`timescale 1ns/1ps
`default_nettype none

module tb_clock (
    output logic clk,
    output logic init
);

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk; // 8 ns period
    end

    initial begin
        init = 1'b1;
        repeat (16) @(posedge clk);
        init <= 1'b0;
    end

endmodule

`default_nettype wire

// File: cache_assertions.sv
`timescale 1ns/1ps
`default_nettype none

module cache_assertions (
    input  logic                clk,
    input  logic                init,
    input  logic                cpu_req_valid,
    input  logic                cpu_ack,
    input  logic                mem_req_valid,
    input  cache_pkg::mem_req_t mem_req,
    input  logic                hit0,
    input  logic                hit1
);

    int fail_count = 0; // failed assertions so far

    one_way_match: assert property (@(posedge clk) disable iff (init) !(hit0 && hit1))
        else begin
            fail_count++;
            $error("both ways match the same tag");
        end

    // ack may trail req by one cycle on the falling edge
    ack_needs_req: assert property (@(posedge clk) disable iff (init)
        cpu_ack |-> (cpu_req_valid || $past(cpu_req_valid)))
        else begin
            fail_count++;
            $error("cpu_ack high without a request");
        end

    mem_req_stable: assert property (@(posedge clk) disable iff (init)
        (mem_req_valid && $past(mem_req_valid)) |-> $stable(mem_req))
        else begin
            fail_count++;
            $error("mem_req changed while mem_req_valid was high");
        end

endmodule

bind cache_ctrl cache_assertions chk0 (
    .clk           (clk),
    .init          (init),
    .cpu_req_valid (cpu_req_valid),
    .cpu_ack       (cpu_ack),
    .mem_req_valid (mem_req_valid),
    .mem_req       (mem_req),
    .hit0          (hit0),
    .hit1          (hit1)
);

`default_nettype wire

// File: cache_top.sv
`timescale 1ns/1ps
`default_nettype none

module cache_top (
    input  logic                 clk,
    input  logic                 init,
    input  logic                 cpu_req_valid,
    input  cache_pkg::cpu_req_t  cpu_req,
    output logic                 cpu_ack,
    output cache_pkg::cpu_resp_t cpu_resp,
    output logic                 mem_req_valid,
    output cache_pkg::mem_req_t  mem_req,
    input  logic                 mem_ack,
    input  cache_pkg::block_t    mem_rdata
);

    cache_pkg::index_t     index;      // shared by both arrays
    logic [1:0]            tag_we;
    cache_pkg::tag_entry_t tag_wentry;
    cache_pkg::tag_entry_t tag_rentry0;
    cache_pkg::tag_entry_t tag_rentry1;
    logic                  data_way;
    cache_pkg::strobe_t    data_strobe;
    cache_pkg::block_t     data_wdata;
    cache_pkg::block_t     data_rdata0;
    cache_pkg::block_t     data_rdata1;
    logic                  lfsr_step;
    logic                  way_bit;

    cache_ctrl ctrl0 (
        .clk           (clk),
        .init          (init),
        .cpu_req_valid (cpu_req_valid),
        .cpu_req       (cpu_req),
        .cpu_ack       (cpu_ack),
        .cpu_resp      (cpu_resp),
        .mem_req_valid (mem_req_valid),
        .mem_req       (mem_req),
        .mem_ack       (mem_ack),
        .mem_rdata     (mem_rdata),
        .tag_index     (index),
        .tag_we        (tag_we),
        .tag_wentry    (tag_wentry),
        .tag_rentry0   (tag_rentry0),
        .tag_rentry1   (tag_rentry1),
        .data_way      (data_way),
        .data_strobe   (data_strobe),
        .data_wdata    (data_wdata),
        .data_rdata0   (data_rdata0),
        .data_rdata1   (data_rdata1),
        .lfsr_step     (lfsr_step),
        .way_bit       (way_bit)
    );

    tag_array tags0 (
        .clk     (clk),
        .init    (init),
        .index   (index),
        .we      (tag_we),
        .wentry  (tag_wentry),
        .rentry0 (tag_rentry0),
        .rentry1 (tag_rentry1)
    );

    data_array data0 (
        .clk    (clk),
        .index  (index),
        .way    (data_way),
        .strobe (data_strobe),
        .wdata  (data_wdata),
        .rdata0 (data_rdata0),
        .rdata1 (data_rdata1)
    );

    lfsr_8bit lfsr0 (
        .clk     (clk),
        .init    (init),
        .step    (lfsr_step),
        .way_bit (way_bit)
    );

endmodule

`default_nettype wire

// File: cache_ctrl.sv
`timescale 1ns/1ps
`default_nettype none

module cache_ctrl (
    input  logic                  clk,
    input  logic                  init,
    input  logic                  cpu_req_valid,
    input  cache_pkg::cpu_req_t   cpu_req,
    output logic                  cpu_ack,
    output cache_pkg::cpu_resp_t  cpu_resp,
    output logic                  mem_req_valid,
    output cache_pkg::mem_req_t   mem_req,
    input  logic                  mem_ack,
    input  cache_pkg::block_t     mem_rdata,
    output cache_pkg::index_t     tag_index,
    output logic [1:0]            tag_we,
    output cache_pkg::tag_entry_t tag_wentry,
    input  cache_pkg::tag_entry_t tag_rentry0,
    input  cache_pkg::tag_entry_t tag_rentry1,
    output logic                  data_way,
    output cache_pkg::strobe_t    data_strobe,
    output cache_pkg::block_t     data_wdata,
    input  cache_pkg::block_t     data_rdata0,
    input  cache_pkg::block_t     data_rdata1,
    output logic                  lfsr_step,
    input  logic                  way_bit
);

    cache_pkg::ctrl_state_t state;
    cache_pkg::cpu_req_t    req_q;
    logic                   missed; // first lookup of this request missed
    logic                   victim;
    logic                   victim_way;
    cache_pkg::tag_t        req_tag;
    cache_pkg::index_t      req_index;
    cache_pkg::offset_t     req_offset;
    logic                   hit0;
    logic                   hit1;
    logic                   hit;
    logic                   refill_done;
    cache_pkg::block_t      hit_block;
    cache_pkg::block_t      store_block;
    cache_pkg::block_t      merged;
    cache_pkg::word_t       hit_word;
    cache_pkg::word_t       shifted;
    cache_pkg::word_t       load_word;
    cache_pkg::strobe_t     store_strobe;

    assign {req_tag, req_index, req_offset} = req_q.addr;

    assign hit0 = tag_rentry0.valid && (tag_rentry0.tag == req_tag);
    assign hit1 = tag_rentry1.valid && (tag_rentry1.tag == req_tag);
    assign hit  = hit0 | hit1;

    // invalid way first, way 0 before way 1
    assign victim_way = !tag_rentry0.valid ? 1'b0 :
                        !tag_rentry1.valid ? 1'b1 : way_bit;

    assign hit_block   = hit1 ? data_rdata1 : data_rdata0;
    assign hit_word    = req_offset[2] ? hit_block[63:32] : hit_block[31:0];
    assign shifted     = hit_word >> {req_offset[1:0], 3'b000};
    assign store_block = {2{req_q.wdata}}; // data sits in its lanes, same in both halves

    always_comb begin
        case (req_q.size)
            cache_pkg::SZ_BYTE: load_word = {24'b0, shifted[7:0]};
            cache_pkg::SZ_HALF: load_word = {16'b0, shifted[15:0]};
            default:            load_word = shifted;
        endcase
    end

    always_comb begin
        case (req_q.size)
            cache_pkg::SZ_BYTE: store_strobe = cache_pkg::strobe_t'(8'h01) << req_offset;
            cache_pkg::SZ_HALF: store_strobe = cache_pkg::strobe_t'(8'h03) << req_offset;
            default:            store_strobe = cache_pkg::strobe_t'(8'h0f) << req_offset;
        endcase
    end

    // updated block for the write-through
    always_comb begin
        for (int b = 0; b < cache_pkg::BLOCK_BYTES; b++) begin
            merged[8*b +: 8] = store_strobe[b] ? store_block[8*b +: 8] : hit_block[8*b +: 8];
        end
    end

    assign refill_done = (state == cache_pkg::REFILL) && mem_ack;

    // arrays read straight from the request while idle
    assign tag_index  = (state == cache_pkg::IDLE) ?
                        cpu_req.addr[cache_pkg::OFFSET_W +: cache_pkg::INDEX_W] : req_index;
    assign tag_we     = refill_done ? (victim ? 2'b10 : 2'b01) : 2'b00;
    assign tag_wentry = '{valid: 1'b1, tag: req_tag};

    assign data_way    = (state == cache_pkg::STORE) ? hit1 : victim;
    assign data_strobe = refill_done                 ? '1 :
                         (state == cache_pkg::STORE) ? store_strobe : '0;
    assign data_wdata  = (state == cache_pkg::STORE) ? store_block : mem_rdata;
    assign lfsr_step   = refill_done;

    assign mem_req_valid = (state == cache_pkg::REFILL) || (state == cache_pkg::WT_REQ);

    always_ff @(posedge clk or posedge init) begin
        if (init) begin
            state   <= cache_pkg::IDLE;
            cpu_ack <= 1'b0;
            missed  <= 1'b0;
        end else begin
            case (state)
                cache_pkg::IDLE: begin
                    if (cpu_req_valid) begin
                        missed <= 1'b0;
                        state  <= cache_pkg::LOOKUP;
                    end
                end
                cache_pkg::LOOKUP: begin
                    if (!hit) begin
                        missed <= 1'b1;
                        state  <= cache_pkg::REFILL;
                    end else if (req_q.write) begin
                        state <= cache_pkg::STORE;
                    end else begin
                        state <= cache_pkg::RESP;
                    end
                end
                cache_pkg::REFILL:      if (mem_ack) state <= cache_pkg::REFILL_DROP;
                cache_pkg::REFILL_DROP: if (!mem_ack) state <= cache_pkg::LOOKUP; // re-read the set
                cache_pkg::STORE:       state <= cache_pkg::WT_REQ;
                cache_pkg::WT_REQ:      if (mem_ack) state <= cache_pkg::WT_DROP;
                cache_pkg::WT_DROP:     if (!mem_ack) state <= cache_pkg::RESP;
                cache_pkg::RESP: begin
                    if (!cpu_ack) begin
                        cpu_ack <= 1'b1;
                    end else if (!cpu_req_valid) begin
                        cpu_ack <= 1'b0;
                        state   <= cache_pkg::IDLE;
                    end
                end
                default: state <= cache_pkg::IDLE;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (state == cache_pkg::IDLE && cpu_req_valid) begin
            req_q <= cpu_req;
        end
        if (state == cache_pkg::LOOKUP) begin
            victim   <= victim_way;
            cpu_resp <= '{rdata: req_q.write ? '0 : load_word, hit: !missed};
            if (!hit) begin
                mem_req <= '{write: 1'b0, blk_addr: {req_tag, req_index}, wdata: '0};
            end
        end
        if (state == cache_pkg::STORE) begin
            mem_req <= '{write: 1'b1, blk_addr: {req_tag, req_index}, wdata: merged};
        end
    end

endmodule

`default_nettype wire

// File: data_array.sv
`timescale 1ns/1ps
`default_nettype none

module data_array (
    input  logic               clk,
    input  cache_pkg::index_t  index,
    input  logic               way,
    input  cache_pkg::strobe_t strobe,
    input  cache_pkg::block_t  wdata,
    output cache_pkg::block_t  rdata0,
    output cache_pkg::block_t  rdata1
);

    cache_pkg::block_t blocks0 [cache_pkg::N_SETS];
    cache_pkg::block_t blocks1 [cache_pkg::N_SETS];

    always_ff @(posedge clk) begin
        // byte lanes under strobe, one way at a time
        for (int b = 0; b < cache_pkg::BLOCK_BYTES; b++) begin
            if (strobe[b]) begin
                if (way) begin
                    blocks1[index][8*b +: 8] <= wdata[8*b +: 8];
                end else begin
                    blocks0[index][8*b +: 8] <= wdata[8*b +: 8];
                end
            end
        end
        rdata0 <= blocks0[index];
        rdata1 <= blocks1[index];
    end

endmodule

`default_nettype wire

// File: tag_array.sv
`timescale 1ns/1ps
`default_nettype none

module tag_array (
    input  logic                  clk,
    input  logic                  init,
    input  cache_pkg::index_t     index,
    input  logic [1:0]            we,     // one bit per way
    input  cache_pkg::tag_entry_t wentry,
    output cache_pkg::tag_entry_t rentry0,
    output cache_pkg::tag_entry_t rentry1
);

    logic [cache_pkg::N_SETS-1:0] valid0;
    logic [cache_pkg::N_SETS-1:0] valid1;
    cache_pkg::tag_t              tags0 [cache_pkg::N_SETS];
    cache_pkg::tag_t              tags1 [cache_pkg::N_SETS];

    // valid bits come up cleared
    always_ff @(posedge clk or posedge init) begin
        if (init) begin
            valid0 <= '0;
            valid1 <= '0;
        end else begin
            if (we[0]) valid0[index] <= wentry.valid;
            if (we[1]) valid1[index] <= wentry.valid;
        end
    end

    always_ff @(posedge clk) begin
        if (we[0]) tags0[index] <= wentry.tag;
        if (we[1]) tags1[index] <= wentry.tag;
        // registered read, returns the old entry on a same-cycle write
        rentry0 <= '{valid: valid0[index], tag: tags0[index]};
        rentry1 <= '{valid: valid1[index], tag: tags1[index]};
    end

endmodule

`default_nettype wire

// File: lfsr_8bit.sv
`timescale 1ns/1ps
`default_nettype none

// x^8 + x^6 + x^5 + x^4 + 1, maximal length
module lfsr_8bit (
    input  logic clk,
    input  logic init,
    input  logic step,
    output logic way_bit
);

    logic [7:0] q;
    logic       feedback;

    assign feedback = q[7] ^ q[5] ^ q[4] ^ q[3];

    always_ff @(posedge clk or posedge init) begin
        if (init) begin
            q <= cache_pkg::LFSR_SEED;
        end else if (step) begin
            q <= {q[6:0], feedback}; // advances only on refills
        end
    end

    assign way_bit = q[0];

endmodule

`default_nettype wire

// File: cache_pkg.sv
`default_nettype none

package cache_pkg;

    localparam int ADDR_W      = 32;
    localparam int BLOCK_BYTES = 8;
    localparam int N_SETS      = 64;
    localparam int OFFSET_W    = $clog2(BLOCK_BYTES);
    localparam int INDEX_W     = $clog2(N_SETS);
    localparam int TAG_W       = ADDR_W - INDEX_W - OFFSET_W;

    localparam logic [7:0] LFSR_SEED = 8'hb4; // any nonzero value

    typedef logic [ADDR_W-1:0]            addr_t;
    typedef logic [31:0]                  word_t;
    typedef logic [8*BLOCK_BYTES-1:0]     block_t;
    typedef logic [TAG_W-1:0]             tag_t;
    typedef logic [INDEX_W-1:0]           index_t;
    typedef logic [OFFSET_W-1:0]          offset_t;
    typedef logic [ADDR_W-OFFSET_W-1:0]   blk_addr_t;
    typedef logic [1:0]                   size_t;
    typedef logic [BLOCK_BYTES-1:0]       strobe_t;

    // access sizes
    localparam size_t SZ_BYTE = 2'd0;
    localparam size_t SZ_HALF = 2'd1;
    localparam size_t SZ_WORD = 2'd2;

    typedef struct packed {
        logic  write;
        size_t size;
        addr_t addr;
        word_t wdata; // already placed in its byte lanes of the word
    } cpu_req_t;

    typedef struct packed {
        word_t rdata;
        logic  hit;   // no refill was needed
    } cpu_resp_t;

    typedef struct packed {
        logic      write;
        blk_addr_t blk_addr;
        block_t    wdata;
    } mem_req_t;

    typedef struct packed {
        logic valid;
        tag_t tag;
    } tag_entry_t;

    typedef enum logic [2:0] {
        IDLE,
        LOOKUP,
        REFILL,
        REFILL_DROP,
        STORE,
        WT_REQ,
        WT_DROP,
        RESP
    } ctrl_state_t;

endpackage

`default_nettype wire
